//--- verilog/soc_pkg.sv
// soc_pkg
// shared bus widths, MMIO address map, debounce timing and the
// bus address union used by the mapper
package soc_pkg;

	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;

	// word-address bits per memory
	localparam int BOOT_AW    = 4;
	localparam int SCRATCH_AW = 8;
	localparam int MAIN_AW    = 10;

	// MMIO page numbers, every other page is unmapped
	localparam logic [3:0] DEV_BOOT    = 4'd0;
	localparam logic [3:0] DEV_SCRATCH = 4'd1;
	localparam logic [3:0] DEV_GPIO    = 4'd2;

	localparam logic [DATA_W-1:0] UNMAPPED_DATA = 32'hdead_beef;

	// cycles an input must hold before the debounced copy follows
	localparam int DEBOUNCE_CYCLES = 8;
	localparam int DEBOUNCE_CW     = $clog2(DEBOUNCE_CYCLES + 1);

	// main memory view, flag low
	typedef struct packed {
		logic        is_mmio;
		logic [28:0] word;
		logic [1:0]  byte_off;
	} mem_view_t;

	// MMIO view, flag high
	typedef struct packed {
		logic        is_mmio;
		logic [14:0] unused;
		logic [3:0]  page;
		logic [9:0]  offset;
		logic [1:0]  byte_off;
	} mmio_view_t;

	typedef union packed {
		mem_view_t  mem;
		mmio_view_t mmio;
	} bus_addr_u;

endpackage

//--- verilog/debounce.sv
// debounce
// per-bit stability filter for mechanical inputs, the output follows
// after the synchronized input has differed for DEBOUNCE_CYCLES cycles
module debounce import soc_pkg::*; #(
	parameter int N = 2
) (
	input  logic         i_clk,
	input  logic         i_arst_n,
	input  logic [N-1:0] i_btn,
	output logic [N-1:0] o_state
);
	logic [N-1:0]           sync_q1;
	logic [N-1:0]           sync_q2;
	logic [DEBOUNCE_CW-1:0] cnt_q [N];

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
			o_state <= '0;
			for (int k = 0; k < N; k++)
				cnt_q[k] <= '0;
		end else begin
			// inputs are asynchronous to i_clk
			sync_q1 <= i_btn;
			sync_q2 <= sync_q1;
			for (int k = 0; k < N; k++) begin
				if (sync_q2[k] == o_state[k]) begin
					cnt_q[k] <= '0;
				end else if (cnt_q[k] == DEBOUNCE_CW'(DEBOUNCE_CYCLES - 1)) begin
					o_state[k] <= sync_q2[k];
					cnt_q[k]   <= '0;
				end else begin
					cnt_q[k] <= cnt_q[k] + 1'b1;
				end
			end
		end
	end

endmodule

//--- verilog/gpio_regs.sv
// gpio_regs
// LED register at offset 0, debounced buttons and switches at offset 1
module gpio_regs import soc_pkg::*; (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic              i_a,
	input  logic [DATA_W-1:0] i_d,
	input  logic              i_we,
	input  logic              i_rd,
	output logic [DATA_W-1:0] o_spo,
	output logic              o_ready,
	input  logic [1:0]        i_sw,
	input  logic [1:0]        i_btn,
	output logic [3:0]        o_led
);
	logic [1:0] sw_db;
	logic [1:0] btn_db;
	logic [3:0] led_q;

	debounce #(.N(2)) u_sw_db (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_btn    (i_sw),
		.o_state  (sw_db)
	);

	debounce #(.N(2)) u_btn_db (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_btn    (i_btn),
		.o_state  (btn_db)
	);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			led_q   <= '0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= (i_we || i_rd) && !o_ready;
			// input word is read only, writes there are dropped
			if (i_we && !i_a)
				led_q <= i_d[3:0];
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rd)
			o_spo <= i_a ? {{(DATA_W-4){1'b0}}, btn_db, sw_db} : {{(DATA_W-4){1'b0}}, led_q};
	end

	assign o_led = led_q;

endmodule

//--- verilog/boot_rom.sv
// boot_rom
// clocked read-only boot memory with contents loaded from a hex file
module boot_rom import soc_pkg::*; (
	input  logic               i_clk,
	input  logic [BOOT_AW-1:0] i_a,
	input  logic               i_rd,
	output logic [DATA_W-1:0]  o_spo,
	output logic               o_ready
);
	logic [DATA_W-1:0] rom [2**BOOT_AW];
	logic              ready_q;

	initial begin
		$readmemh("verilog/boot_rom.hex", rom);
	end

	always_ff @(posedge i_clk) begin
		if (i_rd)
			o_spo <= rom[i_a];
		// one pulse per strobe even while rd is still held
		ready_q <= i_rd && !ready_q;
	end

	assign o_ready = ready_q;

endmodule

//--- verilog/simple_ram.sv
// simple_ram
// single-port word RAM with registered read data and a one-cycle
// ready pulse after each read or write strobe
module simple_ram import soc_pkg::*; #(
	parameter int AW = 8
) (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic [AW-1:0]     i_a,
	input  logic [DATA_W-1:0] i_d,
	input  logic              i_we,
	input  logic              i_rd,
	output logic [DATA_W-1:0] o_spo,
	output logic              o_ready
);
	logic [DATA_W-1:0] mem [2**AW];

	always_ff @(posedge i_clk) begin
		if (i_we)
			mem[i_a] <= i_d;
		if (i_rd)
			o_spo <= mem[i_a];
	end

	// strobe stays up through the ready cycle, so drop after one pulse
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_ready <= 1'b0;
		else
			o_ready <= (i_we || i_rd) && !o_ready;
	end

endmodule

//--- verilog/bus_arbiter.sv
// bus_arbiter
// two-host fixed-priority arbiter for the shared bus, host 0 wins ties
// and a grant is held until its host drops req
module bus_arbiter import soc_pkg::*; (
	input  logic              i_clk,
	input  logic              i_arst_n,

	input  logic              i_req0,
	output logic              o_gnt0,
	input  logic [ADDR_W-1:0] i_a0,
	input  logic [DATA_W-1:0] i_d0,
	input  logic              i_we0,
	input  logic              i_rd0,
	output logic [DATA_W-1:0] o_spo0,
	output logic              o_ready0,

	input  logic              i_req1,
	output logic              o_gnt1,
	input  logic [ADDR_W-1:0] i_a1,
	input  logic [DATA_W-1:0] i_d1,
	input  logic              i_we1,
	input  logic              i_rd1,
	output logic [DATA_W-1:0] o_spo1,
	output logic              o_ready1,

	output logic [ADDR_W-1:0] o_a,
	output logic [DATA_W-1:0] o_d,
	output logic              o_we,
	output logic              o_rd,
	input  logic [DATA_W-1:0] i_spo,
	input  logic              i_ready
);
	logic gnt0_q;
	logic gnt1_q;

	// owner keeps the bus until req falls, a new grant only from idle
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			gnt0_q <= 1'b0;
			gnt1_q <= 1'b0;
		end else if (gnt0_q) begin
			if (!i_req0)
				gnt0_q <= 1'b0;
		end else if (gnt1_q) begin
			if (!i_req1)
				gnt1_q <= 1'b0;
		end else if (i_req0) begin
			gnt0_q <= 1'b1;
		end else if (i_req1) begin
			gnt1_q <= 1'b1;
		end
	end

	assign o_gnt0 = gnt0_q;
	assign o_gnt1 = gnt1_q;

	assign o_a  = gnt1_q ? i_a1 : i_a0;
	assign o_d  = gnt1_q ? i_d1 : i_d0;
	// no strobe on an idle bus
	assign o_we = (gnt0_q & i_we0) | (gnt1_q & i_we1);
	assign o_rd = (gnt0_q & i_rd0) | (gnt1_q & i_rd1);

	assign o_ready0 = gnt0_q & i_ready;
	assign o_ready1 = gnt1_q & i_ready;
	assign o_spo0   = gnt0_q ? i_spo : '0;
	assign o_spo1   = gnt1_q ? i_spo : '0;

endmodule

//--- verilog/bus_mapper.sv
// bus_mapper
// splits main memory from MMIO on the top address bit, decodes the MMIO
// page and answers unmapped pages and boot ROM writes locally
module bus_mapper import soc_pkg::*; (
	input  logic                  i_clk,
	input  logic                  i_arst_n,

	input  logic [ADDR_W-1:0]     i_a,
	input  logic [DATA_W-1:0]     i_d,
	input  logic                  i_we,
	input  logic                  i_rd,
	output logic [DATA_W-1:0]     o_spo,
	output logic                  o_ready,

	output logic [MAIN_AW-1:0]    o_mem_a,
	output logic [DATA_W-1:0]     o_mem_d,
	output logic                  o_mem_we,
	output logic                  o_mem_rd,
	input  logic [DATA_W-1:0]     i_mem_spo,
	input  logic                  i_mem_ready,

	output logic [BOOT_AW-1:0]    o_boot_a,
	output logic                  o_boot_rd,
	input  logic [DATA_W-1:0]     i_boot_spo,
	input  logic                  i_boot_ready,

	output logic [SCRATCH_AW-1:0] o_scr_a,
	output logic [DATA_W-1:0]     o_scr_d,
	output logic                  o_scr_we,
	output logic                  o_scr_rd,
	input  logic [DATA_W-1:0]     i_scr_spo,
	input  logic                  i_scr_ready,

	output logic                  o_gpio_a,
	output logic [DATA_W-1:0]     o_gpio_d,
	output logic                  o_gpio_we,
	output logic                  o_gpio_rd,
	input  logic [DATA_W-1:0]     i_gpio_spo,
	input  logic                  i_gpio_ready
);
	bus_addr_u addr;
	logic      sel_mem;
	logic      sel_boot;
	logic      sel_scr;
	logic      sel_gpio;
	logic      sel_local;
	logic      local_ready_q;

	assign addr = i_a;

	assign sel_mem  = !addr.mem.is_mmio;
	assign sel_boot = addr.mmio.is_mmio && (addr.mmio.page == DEV_BOOT);
	assign sel_scr  = addr.mmio.is_mmio && (addr.mmio.page == DEV_SCRATCH);
	assign sel_gpio = addr.mmio.is_mmio && (addr.mmio.page == DEV_GPIO);

	// ROM has no write port, so its writes complete here with the unmapped pages
	assign sel_local = (addr.mmio.is_mmio && !sel_boot && !sel_scr && !sel_gpio) ||
		(sel_boot && i_we);

	assign o_mem_a  = addr.mem.word[MAIN_AW-1:0];
	assign o_mem_d  = i_d;
	assign o_mem_we = sel_mem & i_we;
	assign o_mem_rd = sel_mem & i_rd;

	assign o_boot_a  = addr.mmio.offset[BOOT_AW-1:0];
	assign o_boot_rd = sel_boot & i_rd;

	assign o_scr_a  = addr.mmio.offset[SCRATCH_AW-1:0];
	assign o_scr_d  = i_d;
	assign o_scr_we = sel_scr & i_we;
	assign o_scr_rd = sel_scr & i_rd;

	assign o_gpio_a  = addr.mmio.offset[0];
	assign o_gpio_d  = i_d;
	assign o_gpio_we = sel_gpio & i_we;
	assign o_gpio_rd = sel_gpio & i_rd;

	// same one-cycle response as a real slave
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			local_ready_q <= 1'b0;
		else
			local_ready_q <= sel_local && (i_we || i_rd) && !local_ready_q;
	end

	always_comb begin
		if (sel_mem) begin
			o_spo   = i_mem_spo;
			o_ready = i_mem_ready;
		end else if (sel_boot) begin
			o_spo   = i_boot_spo;
			o_ready = i_boot_ready | local_ready_q;
		end else if (sel_scr) begin
			o_spo   = i_scr_spo;
			o_ready = i_scr_ready;
		end else if (sel_gpio) begin
			o_spo   = i_gpio_spo;
			o_ready = i_gpio_ready;
		end else begin
			o_spo   = UNMAPPED_DATA;
			o_ready = local_ready_q;
		end
	end

endmodule

//--- verilog/soc_top.sv
// soc_top
// shared-bus fabric with two external hosts, boot ROM, scratch RAM,
// main memory and GPIO
module soc_top import soc_pkg::*; (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic [1:0]        i_sw,
	input  logic [1:0]        i_btn,
	output logic [3:0]        o_led,

	// host 0, cpu side
	input  logic              i_h0_req,
	output logic              o_h0_gnt,
	input  logic [ADDR_W-1:0] i_h0_a,
	input  logic [DATA_W-1:0] i_h0_d,
	input  logic              i_h0_we,
	input  logic              i_h0_rd,
	output logic [DATA_W-1:0] o_h0_spo,
	output logic              o_h0_ready,

	// host 1, boot loader side
	input  logic              i_h1_req,
	output logic              o_h1_gnt,
	input  logic [ADDR_W-1:0] i_h1_a,
	input  logic [DATA_W-1:0] i_h1_d,
	input  logic              i_h1_we,
	input  logic              i_h1_rd,
	output logic [DATA_W-1:0] o_h1_spo,
	output logic              o_h1_ready
);
	// arbitrated bus
	logic [ADDR_W-1:0]     bus_a;
	logic [DATA_W-1:0]     bus_d;
	logic                  bus_we;
	logic                  bus_rd;
	logic [DATA_W-1:0]     bus_spo;
	logic                  bus_ready;

	logic [MAIN_AW-1:0]    mem_a;
	logic [DATA_W-1:0]     mem_d;
	logic                  mem_we;
	logic                  mem_rd;
	logic [DATA_W-1:0]     mem_spo;
	logic                  mem_ready;

	logic [BOOT_AW-1:0]    boot_a;
	logic                  boot_rd;
	logic [DATA_W-1:0]     boot_spo;
	logic                  boot_ready;

	logic [SCRATCH_AW-1:0] scr_a;
	logic [DATA_W-1:0]     scr_d;
	logic                  scr_we;
	logic                  scr_rd;
	logic [DATA_W-1:0]     scr_spo;
	logic                  scr_ready;

	logic                  gpio_a;
	logic [DATA_W-1:0]     gpio_d;
	logic                  gpio_we;
	logic                  gpio_rd;
	logic [DATA_W-1:0]     gpio_spo;
	logic                  gpio_ready;

	bus_arbiter u_arbiter (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_req0   (i_h0_req),
		.o_gnt0   (o_h0_gnt),
		.i_a0     (i_h0_a),
		.i_d0     (i_h0_d),
		.i_we0    (i_h0_we),
		.i_rd0    (i_h0_rd),
		.o_spo0   (o_h0_spo),
		.o_ready0 (o_h0_ready),
		.i_req1   (i_h1_req),
		.o_gnt1   (o_h1_gnt),
		.i_a1     (i_h1_a),
		.i_d1     (i_h1_d),
		.i_we1    (i_h1_we),
		.i_rd1    (i_h1_rd),
		.o_spo1   (o_h1_spo),
		.o_ready1 (o_h1_ready),
		.o_a      (bus_a),
		.o_d      (bus_d),
		.o_we     (bus_we),
		.o_rd     (bus_rd),
		.i_spo    (bus_spo),
		.i_ready  (bus_ready)
	);

	bus_mapper u_mapper (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_a          (bus_a),
		.i_d          (bus_d),
		.i_we         (bus_we),
		.i_rd         (bus_rd),
		.o_spo        (bus_spo),
		.o_ready      (bus_ready),
		.o_mem_a      (mem_a),
		.o_mem_d      (mem_d),
		.o_mem_we     (mem_we),
		.o_mem_rd     (mem_rd),
		.i_mem_spo    (mem_spo),
		.i_mem_ready  (mem_ready),
		.o_boot_a     (boot_a),
		.o_boot_rd    (boot_rd),
		.i_boot_spo   (boot_spo),
		.i_boot_ready (boot_ready),
		.o_scr_a      (scr_a),
		.o_scr_d      (scr_d),
		.o_scr_we     (scr_we),
		.o_scr_rd     (scr_rd),
		.i_scr_spo    (scr_spo),
		.i_scr_ready  (scr_ready),
		.o_gpio_a     (gpio_a),
		.o_gpio_d     (gpio_d),
		.o_gpio_we    (gpio_we),
		.o_gpio_rd    (gpio_rd),
		.i_gpio_spo   (gpio_spo),
		.i_gpio_ready (gpio_ready)
	);

	boot_rom u_boot_rom (
		.i_clk   (i_clk),
		.i_a     (boot_a),
		.i_rd    (boot_rd),
		.o_spo   (boot_spo),
		.o_ready (boot_ready)
	);

	simple_ram #(.AW(SCRATCH_AW)) u_scratch (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_a      (scr_a),
		.i_d      (scr_d),
		.i_we     (scr_we),
		.i_rd     (scr_rd),
		.o_spo    (scr_spo),
		.o_ready  (scr_ready)
	);

	simple_ram #(.AW(MAIN_AW)) u_main (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_a      (mem_a),
		.i_d      (mem_d),
		.i_we     (mem_we),
		.i_rd     (mem_rd),
		.o_spo    (mem_spo),
		.o_ready  (mem_ready)
	);

	gpio_regs u_gpio (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_a      (gpio_a),
		.i_d      (gpio_d),
		.i_we     (gpio_we),
		.i_rd     (gpio_rd),
		.o_spo    (gpio_spo),
		.o_ready  (gpio_ready),
		.i_sw     (i_sw),
		.i_btn    (i_btn),
		.o_led    (o_led)
	);

endmodule

//--- test/tb_clock.sv
// tb_clock
// free-running testbench clock
module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic o_clk
);
	initial begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;
	end

endmodule

//--- test/soc_asserts.sv
// soc_asserts
// checks that only one host holds the bus, that slave ready arrives only
// while a host is granted and that a grant stays while its req is held
module soc_asserts (
	input logic i_clk,
	input logic i_arst_n,
	input logic i_req0,
	input logic i_req1,
	input logic o_gnt0,
	input logic o_gnt1,
	input logic i_ready
);
	a_one_grant: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(o_gnt0 && o_gnt1)) else $error("both bus grants high");

	a_ready_owned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_ready |-> (o_gnt0 || o_gnt1)) else $error("slave ready with no host granted");

	a_hold0: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(o_gnt0 && i_req0) |=> o_gnt0) else $error("host 0 grant lost under req");

	a_hold1: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(o_gnt1 && i_req1) |=> o_gnt1) else $error("host 1 grant lost under req");

endmodule

bind bus_arbiter soc_asserts u_asserts (
	.i_clk    (i_clk),
	.i_arst_n (i_arst_n),
	.i_req0   (i_req0),
	.i_req1   (i_req1),
	.o_gnt0   (o_gnt0),
	.o_gnt1   (o_gnt1),
	.i_ready  (i_ready)
);

//--- test/soc_tb.sv
// soc_tb
// table-driven testbench in which two hosts reach main memory, boot ROM,
// scratch RAM, GPIO and unmapped pages through the shared-bus fabric
module soc_tb import soc_pkg::*; ();
	localparam logic [2:0] OP_WR     = 3'd0;
	localparam logic [2:0] OP_RD     = 3'd1;
	localparam logic [2:0] OP_PINS   = 3'd2;
	localparam logic [2:0] OP_GLITCH = 3'd3;
	localparam logic [2:0] OP_LED    = 3'd4;
	localparam logic [2:0] OP_RACE   = 3'd5;
	localparam int ACCESS_LIMIT  = 32;

	typedef struct packed {
		logic [2:0]  op;
		logic        host;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] wdata2;
		logic [31:0] exp_data;
	} test_t;

	logic        clk;
	logic        arst_n;
	logic [1:0]  sw;
	logic [1:0]  btn;
	logic [3:0]  led;
	logic        h0_req, h0_gnt, h0_we, h0_rd, h0_ready;
	logic        h1_req, h1_gnt, h1_we, h1_rd, h1_ready;
	logic [31:0] h0_a, h0_d, h0_spo;
	logic [31:0] h1_a, h1_d, h1_spo;

	test_t       tests[$];
	logic [31:0] lfsr_q = 32'h2c06f006;
	int          cycle_cnt = 0;
	int          timeout_limit = 0;
	int          n_pass = 0;
	int          n_fail = 0;

	tb_clock #(.PERIOD(4)) u_clock (.o_clk(clk));

	soc_top u_soc_top (
		.i_clk (clk), .i_arst_n (arst_n), .i_sw (sw), .i_btn (btn), .o_led (led),
		.i_h0_req (h0_req), .o_h0_gnt (h0_gnt), .i_h0_a (h0_a), .i_h0_d (h0_d),
		.i_h0_we (h0_we), .i_h0_rd (h0_rd), .o_h0_spo (h0_spo), .o_h0_ready (h0_ready),
		.i_h1_req (h1_req), .o_h1_gnt (h1_gnt), .i_h1_a (h1_a), .i_h1_d (h1_d),
		.i_h1_we (h1_we), .i_h1_rd (h1_rd), .o_h1_spo (h1_spo), .o_h1_ready (h1_ready)
	);

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < n; i++) begin
			w = {w[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
		return w;
	endfunction

	function automatic logic [31:0] mem_addr(input int word);
		return {1'b0, 29'(word), 2'b00};
	endfunction

	function automatic logic [31:0] mmio_addr(input logic [3:0] page, input int off);
		return {1'b1, 15'h0, page, 10'(off), 2'b00};
	endfunction

	function automatic string op_name(input logic [2:0] op);
		case (op)
			OP_WR:     return "write";
			OP_RD:     return "read";
			OP_PINS:   return "pins";
			OP_GLITCH: return "glitch";
			OP_LED:    return "led";
			default:   return "race";
		endcase
	endfunction

	task automatic add_test(input logic [2:0] op, input logic host, input logic [31:0] a,
			input logic [31:0] d, input logic [31:0] d2, input logic [31:0] e);
		tests.push_back('{op: op, host: host, addr: a, wdata: d, wdata2: d2, exp_data: e});
	endtask

	task automatic check_value(input string sig, input logic [31:0] got,
			input logic [31:0] exp_val, inout logic ok);
		if (got !== exp_val) begin
			$display("ERR %s: got %h, expected %h", sig, got, exp_val);
			ok = 1'b0;
		end
	endtask

	task automatic drive_host(input logic host, input logic req, input logic we,
			input logic rd, input logic [31:0] a, input logic [31:0] d);
		if (host) begin
			h1_req <= req;
			h1_we  <= we;
			h1_rd  <= rd;
			h1_a   <= a;
			h1_d   <= d;
		end else begin
			h0_req <= req;
			h0_we  <= we;
			h0_rd  <= rd;
			h0_a   <= a;
			h0_d   <= d;
		end
	endtask

	// one bus access with req and strobe held until ready is seen
	task automatic bus_access(input logic host, input logic is_wr, input logic [31:0] a,
			input logic [31:0] d, output logic [31:0] rdata, output int gnt_cyc,
			output int done_cyc, output logic ok);
		int waited;
		waited = 0;
		ok = 1'b0;
		gnt_cyc = -1;
		done_cyc = -1;
		rdata = '0;
		@(posedge clk);
		drive_host(host, 1'b1, is_wr, !is_wr, a, d);
		while (!ok && waited < ACCESS_LIMIT) begin
			@(posedge clk);
			waited++;
			if (gnt_cyc < 0 && (host ? h1_gnt : h0_gnt))
				gnt_cyc = cycle_cnt;
			if (host ? h1_ready : h0_ready) begin
				ok = 1'b1;
				rdata = host ? h1_spo : h0_spo;
				done_cyc = cycle_cnt;
			end
		end
		drive_host(host, 1'b0, 1'b0, 1'b0, a, d);
		if (!ok)
			$display("no ready for host %0d at address %h within %0d cycles",
				host, a, ACCESS_LIMIT);
	endtask

	task automatic run_test(input int idx);
		test_t       t;
		string       spo_name;
		logic        ok;
		logic        acc_ok;
		logic        acc_ok1;
		logic [31:0] rdata;
		logic [31:0] rdata1;
		int          g0, g1, d0, d1;
		t = tests[idx];
		spo_name = t.host ? "o_h1_spo" : "o_h0_spo";
		ok = 1'b1;
		case (t.op)
			OP_WR: begin
				bus_access(t.host, 1'b1, t.addr, t.wdata, rdata, g0, d0, acc_ok);
				ok = acc_ok;
			end
			OP_LED: check_value("o_led", {28'h0, led}, t.exp_data, ok);
			OP_RACE: begin
				fork
					bus_access(1'b0, 1'b1, t.addr, t.wdata, rdata, g0, d0, acc_ok);
					bus_access(1'b1, 1'b1, t.addr, t.wdata2, rdata1, g1, d1, acc_ok1);
				join
				ok = acc_ok && acc_ok1;
				if (ok && !(g0 >= 0 && g0 < g1 && d0 < d1)) begin
					$display("host 0 was not granted and served before host 1");
					ok = 1'b0;
				end
			end
			OP_PINS: begin
				@(posedge clk);
				sw  <= t.wdata[1:0];
				btn <= t.wdata[3:2];
				repeat (DEBOUNCE_CYCLES + 4) @(posedge clk);
			end
			OP_GLITCH: begin
				// short pulse away from the settled pins, read back while it is held
				@(posedge clk);
				sw  <= t.wdata[1:0];
				btn <= t.wdata[3:2];
				bus_access(t.host, 1'b0, t.addr, 32'h0, rdata, g0, d0, acc_ok);
				@(posedge clk);
				sw  <= t.exp_data[1:0];
				btn <= t.exp_data[3:2];
				if (acc_ok)
					check_value(spo_name, rdata, t.exp_data, ok);
				else
					ok = 1'b0;
				repeat (DEBOUNCE_CYCLES + 4) @(posedge clk);
			end
			default: ;
		endcase
		if (t.op == OP_RD || t.op == OP_PINS || t.op == OP_GLITCH || t.op == OP_RACE) begin
			bus_access(t.host, 1'b0, t.addr, 32'h0, rdata, g0, d0, acc_ok);
			if (acc_ok)
				check_value(spo_name, rdata, t.exp_data, ok);
			else
				ok = 1'b0;
		end
		$display("test %0d %s host %0d addr %h %s", idx, op_name(t.op), t.host, t.addr,
			ok ? "ok" : "failed");
		if (ok)
			n_pass++;
		else
			n_fail++;
	endtask

	task automatic build_table();
		logic [31:0] w [11];
		logic [3:0]  pins;
		for (int i = 0; i < 11; i++)
			w[i] = rand_bits(32);
		// main memory through both hosts
		add_test(OP_WR, 1'b0, mem_addr(3), w[0], 0, 0);
		add_test(OP_WR, 1'b1, mem_addr(100), w[1], 0, 0);
		add_test(OP_WR, 1'b0, mem_addr(1023), w[2], 0, 0);
		add_test(OP_WR, 1'b1, mem_addr(517), w[3], 0, 0);
		add_test(OP_RD, 1'b1, mem_addr(3), 0, 0, w[0]);
		add_test(OP_RD, 1'b0, mem_addr(100), 0, 0, w[1]);
		add_test(OP_RD, 1'b1, mem_addr(1023), 0, 0, w[2]);
		add_test(OP_RD, 1'b0, mem_addr(517), 0, 0, w[3]);
		// boot ROM reads and a write that must leave it unchanged
		add_test(OP_RD, 1'b0, mmio_addr(DEV_BOOT, 0), 0, 0, 32'hb007_0000);
		add_test(OP_RD, 1'b1, mmio_addr(DEV_BOOT, 5), 0, 0, 32'hb007_0005);
		add_test(OP_RD, 1'b0, mmio_addr(DEV_BOOT, 15), 0, 0, 32'hb007_000f);
		add_test(OP_WR, 1'b0, mmio_addr(DEV_BOOT, 5), w[4], 0, 0);
		add_test(OP_RD, 1'b1, mmio_addr(DEV_BOOT, 5), 0, 0, 32'hb007_0005);
		// scratch words apart from main memory words of the same index
		add_test(OP_WR, 1'b0, mmio_addr(DEV_SCRATCH, 3), w[5], 0, 0);
		add_test(OP_WR, 1'b1, mmio_addr(DEV_SCRATCH, 100), w[6], 0, 0);
		add_test(OP_RD, 1'b0, mmio_addr(DEV_SCRATCH, 3), 0, 0, w[5]);
		add_test(OP_RD, 1'b1, mem_addr(3), 0, 0, w[0]);
		add_test(OP_RD, 1'b0, mmio_addr(DEV_SCRATCH, 100), 0, 0, w[6]);
		add_test(OP_RD, 1'b1, mem_addr(100), 0, 0, w[1]);
		// gpio LEDs, input word and glitch filtering
		add_test(OP_WR, 1'b0, mmio_addr(DEV_GPIO, 0), w[7], 0, 0);
		add_test(OP_LED, 1'b0, 0, 0, 0, {28'h0, w[7][3:0]});
		add_test(OP_RD, 1'b1, mmio_addr(DEV_GPIO, 0), 0, 0, {28'h0, w[7][3:0]});
		add_test(OP_WR, 1'b1, mmio_addr(DEV_GPIO, 1), {w[8][31:4], ~w[7][3:0]}, 0, 0);
		add_test(OP_LED, 1'b0, 0, 0, 0, {28'h0, w[7][3:0]});
		pins = 4'(rand_bits(4));
		add_test(OP_PINS, 1'b0, mmio_addr(DEV_GPIO, 1), {28'h0, pins}, 0, {28'h0, pins});
		pins = ~pins;
		add_test(OP_PINS, 1'b1, mmio_addr(DEV_GPIO, 1), {28'h0, pins}, 0, {28'h0, pins});
		add_test(OP_GLITCH, 1'b0, mmio_addr(DEV_GPIO, 1), {28'h0, ~pins}, 0, {28'h0, pins});
		// unmapped pages
		add_test(OP_RD, 1'b0, mmio_addr(4'd3, 0), 0, 0, 32'hdead_beef);
		add_test(OP_RD, 1'b1, mmio_addr(4'd15, 1023), 0, 0, 32'hdead_beef);
		add_test(OP_WR, 1'b0, mmio_addr(4'd7, 12), w[9], 0, 0);
		// same-cycle requests to one word where host 1 lands last
		add_test(OP_RACE, 1'b0, mem_addr(42), w[9], w[10], w[10]);
		timeout_limit = tests.size() * 16 + 4 * DEBOUNCE_CYCLES + 200;
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
			$display("timeout, run still busy after %0d cycles", cycle_cnt);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		arst_n <= 1'b0;
		sw     <= 2'b00;
		btn    <= 2'b00;
		h0_req <= 1'b0;
		h0_we  <= 1'b0;
		h0_rd  <= 1'b0;
		h0_a   <= '0;
		h0_d   <= '0;
		h1_req <= 1'b0;
		h1_we  <= 1'b0;
		h1_rd  <= 1'b0;
		h1_a   <= '0;
		h1_d   <= '0;
		build_table();
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		for (int i = 0; i < tests.size(); i++)
			run_test(i);
		$display("tests %0d, passed %0d, failed %0d", tests.size(), n_pass, n_fail);
		if (n_fail == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- verilog/boot_rom.hex
// one 32-bit boot word per line, word k holds b0070000 plus k
b0070000
b0070001
b0070002
b0070003
b0070004
b0070005
b0070006
b0070007
b0070008
b0070009
b007000a
b007000b
b007000c
b007000d
b007000e
b007000f

//--- vlog.f
verilog/soc_pkg.sv
verilog/debounce.sv
verilog/gpio_regs.sv
verilog/boot_rom.sv
verilog/simple_ram.sv
verilog/bus_arbiter.sv
verilog/bus_mapper.sv
verilog/soc_top.sv
test/tb_clock.sv
test/soc_asserts.sv
test/soc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module soc_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vsoc_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
	exit 0
fi
exit 1
